// ==== cache_top.f ====
mem_pkg.sv
cache_pkg.sv
steer_if.sv
wait_state_ctr.sv
cache_ctrl.sv
cache_store.sv
data_steer.sv
cache_top.sv
tb_cache_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cache_top -f cache_top.f \
	&& ./obj_dir/Vtb_cache_top > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "^RESULT: PASS$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tb_cache_top.sv ====
module tb_cache_top
	import mem_pkg::*;
	import cache_pkg::*;
();

	// the limit is twice the cycles of about 200 accesses at 5+WAIT_STATES each, plus reset.
	localparam int MAX_ACCESSES = 200;
	localparam int CYCLE_LIMIT  = MAX_ACCESSES * (5 + WAIT_STATES) * 2 + 200;
	localparam int MIX_ACCESSES = 150;
	localparam int MEM_WORDS    = 1 << ADDR_W;

	logic              clock;
	logic              arst_n;
	logic              p_strobe;
	rw_e               p_rw;
	logic [ADDR_W-1:0] p_addr;
	logic [DATA_W-1:0] p_wdata;
	logic [DATA_W-1:0] p_rdata;
	logic              p_ready;
	logic              sys_strobe;
	rw_e               sys_rw;
	logic [ADDR_W-1:0] sys_addr;
	logic [DATA_W-1:0] sys_wdata;
	logic [DATA_W-1:0] sys_rdata;

	logic [DATA_W-1:0] sys_mem [MEM_WORDS];
	logic [DATA_W-1:0] exp_mem [MEM_WORDS];
	int                sys_reads = 0;
	int                sys_writes = 0;
	rw_e               last_rw = RW_READ;
	logic [ADDR_W-1:0] last_addr = '0;
	logic [DATA_W-1:0] last_wdata = '0;

	logic [TAG_W-1:0]  ref_tag [LINES];
	logic [LINES-1:0]  ref_valid;
	int                exp_reads = 0;
	int                exp_writes = 0;

	logic [31:0] lfsr_q = 32'h28e3;
	int          cycle_count = 0;
	int          error_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_errors_start = 0;
	string       cur_test = "";

	cache_top UUT (
		.clock      (clock),
		.arst_n     (arst_n),
		.p_strobe   (p_strobe),
		.p_rw       (p_rw),
		.p_addr     (p_addr),
		.p_wdata    (p_wdata),
		.p_rdata    (p_rdata),
		.p_ready    (p_ready),
		.sys_strobe (sys_strobe),
		.sys_rw     (sys_rw),
		.sys_addr   (sys_addr),
		.sys_wdata  (sys_wdata),
		.sys_rdata  (sys_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// the system memory has no acknowledge and always shows the word at sys_addr.
	assign sys_rdata = sys_mem[sys_addr];

	always @(posedge clock) begin
		if (sys_strobe) begin
			last_rw    <= sys_rw;
			last_addr  <= sys_addr;
			last_wdata <= sys_wdata;
			if (sys_rw == RW_WRITE) begin
				sys_mem[sys_addr] <= sys_wdata;
				sys_writes <= sys_writes + 1;
			end else begin
				sys_reads <= sys_reads + 1;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// galois form of x^32 + x^31 + x^29 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'hd000_0001) : (state >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			value  = {value[14:0], lfsr_q[0]};
		end
	endtask

	function automatic logic ref_hit(input logic [ADDR_W-1:0] addr);
		logic [INDEX_W-1:0] idx;
		idx = addr[INDEX_W-1:0];
		return ref_valid[idx] && (ref_tag[idx] == addr[ADDR_W-1:INDEX_W]);
	endfunction

	// a read miss fetches and every write goes through, so both leave addr in its line.
	task automatic ref_access(input rw_e rw, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		logic [INDEX_W-1:0] idx;
		idx = addr[INDEX_W-1:0];
		if (rw == RW_WRITE) begin
			exp_writes++;
			exp_mem[addr] = wdata;
		end else if (!ref_hit(addr)) begin
			exp_reads++;
		end
		ref_valid[idx] = 1'b1;
		ref_tag[idx]   = addr[ADDR_W-1:INDEX_W];
	endtask

	task automatic start_test(input string name);
		cur_test          = name;
		test_errors_start = error_count;
	endtask

	task automatic finish_test();
		tests_run++;
		if (error_count == test_errors_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test,
				error_count - test_errors_start);
		end
	endtask

	task automatic check_data(input string what, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("** Error: test %s, %s: expected %h, actual %h",
				cur_test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_addr(input string what, input logic [ADDR_W-1:0] expected,
			input logic [ADDR_W-1:0] actual);
		if (actual !== expected) begin
			$display("** Error: test %s, %s: expected %h, actual %h",
				cur_test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			$display("** Error: test %s, %s: expected %0d, actual %0d",
				cur_test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_rw(input string what, input rw_e expected, input rw_e actual);
		if (actual !== expected) begin
			$display("** Error: test %s, %s: expected %s, actual %s",
				cur_test, what, expected.name(), actual.name());
			error_count++;
		end
	endtask

	// cycles counts the clock edges from the strobe up to the cycle with p_ready.
	task automatic access(input rw_e rw, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
			output int cycles);
		p_strobe = 1'b1;
		p_rw     = rw;
		p_addr   = addr;
		p_wdata  = wdata;
		@(posedge clock);
		#2;
		p_strobe = 1'b0;
		cycles   = 1;
		while (!p_ready) begin
			@(posedge clock);
			#2;
			cycles++;
		end
		rdata = p_rdata;
		@(posedge clock);
		#2;
	endtask

	task automatic checked_access(input rw_e rw, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
			output int cycles);
		ref_access(rw, addr, wdata);
		access(rw, addr, wdata, rdata, cycles);
		if (rw == RW_READ) begin
			check_data("read data", exp_mem[addr], rdata);
		end
		check_count("system reads", exp_reads, sys_reads);
		check_count("system writes", exp_writes, sys_writes);
	endtask

	task automatic reset_and_cold_miss();
		logic [DATA_W-1:0] rdata;
		int cycles;
		start_test("reset_and_cold_miss");
		arst_n = 1'b0;
		repeat (5) begin
			@(posedge clock);
			#2;
			if (p_ready || sys_strobe) begin
				$display("test %s: p_ready or sys_strobe went high during reset", cur_test);
				error_count++;
			end
		end
		arst_n = 1'b1;
		check_data("p_rdata after reset", 16'h0000, p_rdata);
		checked_access(RW_READ, 16'h1234, '0, rdata, cycles);
		check_count("system reads after cold miss", 1, sys_reads);
		check_addr("system read address", 16'h1234, last_addr);
		finish_test();
	endtask

	task automatic read_hit();
		logic [DATA_W-1:0] rdata;
		int cycles;
		start_test("read_hit");
		checked_access(RW_READ, 16'h1234, '0, rdata, cycles);
		check_count("ready latency", 1, cycles);
		check_count("system reads after hit", 1, sys_reads);
		check_data("p_rdata held after ready", exp_mem[16'h1234], p_rdata);
		finish_test();
	endtask

	task automatic write_through_hit();
		logic [DATA_W-1:0] rdata;
		int cycles;
		start_test("write_through_hit");
		checked_access(RW_WRITE, 16'h1234, 16'hbeef, rdata, cycles);
		check_rw("system direction", RW_WRITE, last_rw);
		check_addr("system write address", 16'h1234, last_addr);
		check_data("system write data", 16'hbeef, last_wdata);
		checked_access(RW_READ, 16'h1234, '0, rdata, cycles);
		check_data("read after write", 16'hbeef, rdata);
		check_count("ready latency", 1, cycles);
		finish_test();
	endtask

	task automatic write_miss_allocate();
		logic [DATA_W-1:0] rdata;
		int cycles;
		start_test("write_miss_allocate");
		checked_access(RW_WRITE, 16'h2345, 16'h0f1e, rdata, cycles);
		check_rw("system direction", RW_WRITE, last_rw);
		check_addr("system write address", 16'h2345, last_addr);
		check_data("system write data", 16'h0f1e, last_wdata);
		checked_access(RW_READ, 16'h2345, '0, rdata, cycles);
		check_data("read after write", 16'h0f1e, rdata);
		check_count("ready latency", 1, cycles);
		finish_test();
	endtask

	task automatic conflict_eviction();
		logic [DATA_W-1:0] rdata;
		int cycles;
		int reads_before;
		start_test("conflict_eviction");
		for (int round = 0; round < 6; round++) begin
			reads_before = sys_reads;
			checked_access(RW_READ, (round % 2 == 0) ? 16'h0047 : 16'h0a47, '0, rdata, cycles);
			check_count("system reads per conflict read", reads_before + 1, sys_reads);
		end
		finish_test();
	endtask

	function automatic logic [TAG_W-1:0] mix_tag(input logic [1:0] sel);
		case (sel)
			2'd0: return 12'h000;
			2'd1: return 12'h123;
			2'd2: return 12'h9a5;
			default: return 12'hfff;
		endcase
	endfunction

	// 4 tags over 8 indices gives the 32 addresses of the mix.
	task automatic random_mix();
		logic [15:0] bits;
		logic [15:0] wdata;
		logic [DATA_W-1:0] rdata;
		logic [ADDR_W-1:0] addr;
		rw_e rw;
		int cycles;
		start_test("random_mix");
		for (int n = 0; n < MIX_ACCESSES; n++) begin
			take_bits(3, bits);
			addr = {{TAG_W{1'b0}}, INDEX_W'(bits[2:0])};
			take_bits(2, bits);
			addr[ADDR_W-1:INDEX_W] = mix_tag(bits[1:0]);
			take_bits(1, bits);
			rw    = bits[0] ? RW_WRITE : RW_READ;
			wdata = '0;
			if (rw == RW_WRITE) begin
				take_bits(16, wdata);
			end
			checked_access(rw, addr, wdata, rdata, cycles);
		end
		finish_test();
	endtask

	initial begin
		arst_n    = 1'b0;
		p_strobe  = 1'b0;
		p_rw      = RW_READ;
		p_addr    = '0;
		p_wdata   = '0;
		ref_valid = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			sys_mem[i] = DATA_W'(i) ^ 16'h5a5a;
			exp_mem[i] = DATA_W'(i) ^ 16'h5a5a;
		end
		reset_and_cold_miss();
		read_hit();
		write_through_hit();
		write_miss_allocate();
		conflict_eviction();
		random_mix();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== cache_top.sv ====
module cache_top
	import mem_pkg::*;
	import cache_pkg::*;
(
	input  logic              clock,
	input  logic              arst_n,
	input  logic              p_strobe,
	input  rw_e               p_rw,
	input  logic [ADDR_W-1:0] p_addr,
	input  logic [DATA_W-1:0] p_wdata,
	output logic [DATA_W-1:0] p_rdata,
	output logic              p_ready,
	output logic              sys_strobe,
	output rw_e               sys_rw,
	output logic [ADDR_W-1:0] sys_addr,
	output logic [DATA_W-1:0] sys_wdata,
	input  logic [DATA_W-1:0] sys_rdata
);

	logic              hit;
	logic              wsc_load;
	logic              wsc_carry;
	logic [DATA_W-1:0] line_word;
	logic [DATA_W-1:0] fill_word;

	steer_if steer ();

	// one word per line, so the system sees the processor address unchanged.
	assign sys_addr = p_addr;

	cache_ctrl u_ctrl (
		.clock      (clock),
		.arst_n     (arst_n),
		.p_strobe   (p_strobe),
		.p_rw       (p_rw),
		.hit        (hit),
		.wsc_carry  (wsc_carry),
		.p_ready    (p_ready),
		.sys_strobe (sys_strobe),
		.sys_rw     (sys_rw),
		.wsc_load   (wsc_load),
		.steer      (steer.ctrl)
	);

	wait_state_ctr u_wsc (
		.clock  (clock),
		.arst_n (arst_n),
		.load   (wsc_load),
		.carry  (wsc_carry)
	);

	cache_store u_store (
		.clock     (clock),
		.arst_n    (arst_n),
		.addr      (p_addr),
		.fill_word (fill_word),
		.steer     (steer.dp),
		.hit       (hit),
		.line_word (line_word)
	);

	data_steer u_steer (
		.clock     (clock),
		.arst_n    (arst_n),
		.p_wdata   (p_wdata),
		.sys_rdata (sys_rdata),
		.line_word (line_word),
		.steer     (steer.dp),
		.fill_word (fill_word),
		.p_rdata   (p_rdata),
		.sys_wdata (sys_wdata)
	);

endmodule

// ==== data_steer.sv ====
module data_steer
	import mem_pkg::*;
	import cache_pkg::*;
(
	input  logic              clock,
	input  logic              arst_n,
	input  logic [DATA_W-1:0] p_wdata,
	input  logic [DATA_W-1:0] sys_rdata,
	input  logic [DATA_W-1:0] line_word,
	steer_if.dp               steer,
	output logic [DATA_W-1:0] fill_word,
	output logic [DATA_W-1:0] p_rdata,
	output logic [DATA_W-1:0] sys_wdata
);

	logic [DATA_W-1:0] read_word;
	logic [DATA_W-1:0] hold_q;

	assign fill_word = (steer.cdata_sel == CDATA_SYS) ? sys_rdata : p_wdata;
	assign read_word = (steer.pdata_sel == PDATA_SYS) ? sys_rdata : line_word;

	// the last word handed to the processor stays on p_rdata between accesses.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			hold_q <= '0;
		end else if (steer.open_p) begin
			hold_q <= read_word;
		end
	end

	assign p_rdata = steer.open_p ? read_word : hold_q;

	// system write data is driven only during a write-through strobe.
	assign sys_wdata = steer.open_sys ? p_wdata : '0;

endmodule

// ==== cache_store.sv ====
module cache_store
	import mem_pkg::*;
(
	input  logic              clock,
	input  logic              arst_n,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] fill_word,
	steer_if.dp               steer,
	output logic              hit,
	output logic [DATA_W-1:0] line_word
);

	logic [TAG_W-1:0]   tag_mem  [LINES];
	logic [DATA_W-1:0]  data_mem [LINES];
	logic [LINES-1:0]   valid_q;
	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;

	assign index = addr[INDEX_W-1:0];
	assign tag   = addr[ADDR_W-1:INDEX_W];

	// tag and data are only meaningful behind a set valid bit.
	always_ff @(posedge clock) begin
		if (steer.line_write) begin
			tag_mem[index]  <= tag;
			data_mem[index] <= fill_word;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (steer.line_write) begin
			valid_q[index] <= 1'b1;
		end
	end

	assign hit       = valid_q[index] && (tag_mem[index] == tag);
	assign line_word = data_mem[index];

endmodule

// ==== cache_ctrl.sv ====
module cache_ctrl
	import cache_pkg::*;
(
	input  logic    clock,
	input  logic    arst_n,
	input  logic    p_strobe,
	input  rw_e     p_rw,
	input  logic    hit,
	input  logic    wsc_carry,
	output logic    p_ready,
	output logic    sys_strobe,
	output rw_e     sys_rw,
	output logic    wsc_load,
	steer_if.ctrl   steer
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// a strobe is only looked at in IDLE, so one that arrives mid-access is dropped.
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (p_strobe) begin
					state_d = (p_rw == RW_WRITE) ? WRITE : READ;
				end
			end
			READ: begin
				state_d = hit ? IDLE : READ_MISS;
			end
			READ_MISS: begin
				state_d = READ_SYS;
			end
			READ_SYS: begin
				if (wsc_carry) begin
					state_d = READ_DATA;
				end
			end
			READ_DATA: begin
				state_d = IDLE;
			end
			WRITE: begin
				state_d = hit ? WRITE_HIT : WRITE_MISS;
			end
			WRITE_HIT, WRITE_MISS: begin
				state_d = WRITE_SYS;
			end
			WRITE_SYS: begin
				if (wsc_carry) begin
					state_d = WRITE_DATA;
				end
			end
			WRITE_DATA: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// outputs are decoded from the state alone, except for the read-hit ready.
	always_comb begin
		sys_strobe       = 1'b0;
		sys_rw           = RW_READ;
		wsc_load         = 1'b0;
		steer.line_write = 1'b0;
		steer.cdata_sel  = CDATA_PRO;
		steer.pdata_sel  = PDATA_CAC;
		steer.open_sys   = 1'b0;
		steer.open_p     = 1'b0;
		case (state_q)
			READ: begin
				steer.open_p = 1'b1;
			end
			READ_MISS: begin
				sys_strobe = 1'b1;
				wsc_load   = 1'b1;
			end
			READ_DATA: begin
				// the fetched word fills the line and goes to the processor together.
				steer.line_write = 1'b1;
				steer.cdata_sel  = CDATA_SYS;
				steer.pdata_sel  = PDATA_SYS;
				steer.open_p     = 1'b1;
			end
			WRITE_HIT, WRITE_MISS: begin
				// a miss allocates, so both paths write the line.
				steer.line_write = 1'b1;
				steer.open_sys   = 1'b1;
				sys_strobe       = 1'b1;
				sys_rw           = RW_WRITE;
				wsc_load         = 1'b1;
			end
			default: ;
		endcase
	end

	assign p_ready = ((state_q == READ) && hit)
		|| (state_q == READ_DATA)
		|| (state_q == WRITE_DATA);

	// every system access is followed by at least one wait state.
	assert property (@(posedge clock) disable iff (!arst_n)
		sys_strobe |=> !sys_strobe)
		else $error("sys_strobe held for two cycles");

	assert property (@(posedge clock) disable iff (!arst_n)
		(state_q == IDLE) |-> !p_ready)
		else $error("p_ready raised while idle");

endmodule

// ==== wait_state_ctr.sv ====
module wait_state_ctr
	import mem_pkg::*;
(
	input  logic clock,
	input  logic arst_n,
	input  logic load,
	output logic carry
);

	logic [WSC_W-1:0] count_q;

	// the count parks at zero until the next access loads it again.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else if (load) begin
			count_q <= WSC_W'(WAIT_STATES);
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	assign carry = (count_q == '0) && !load;

	// only one system access is in flight, so a new load always finds the counter idle.
	assert property (@(posedge clock) disable iff (!arst_n)
		load |-> (count_q == '0))
		else $error("wait-state counter reloaded during a system access");

endmodule

// ==== steer_if.sv ====
interface steer_if
	import cache_pkg::*;
();

	logic       line_write;
	cdata_sel_e cdata_sel;
	pdata_sel_e pdata_sel;
	logic       open_sys;
	logic       open_p;

	modport ctrl (
		output line_write,
		output cdata_sel,
		output pdata_sel,
		output open_sys,
		output open_p
	);

	modport dp (
		input line_write,
		input cdata_sel,
		input pdata_sel,
		input open_sys,
		input open_p
	);

endinterface

// ==== cache_pkg.sv ====
package cache_pkg;

	// access sequencer states.
	// a read hit returns from READ and every other path ends in a *_DATA state.
	typedef enum logic [3:0] {
		IDLE       = 4'd0,
		READ       = 4'd1,
		READ_MISS  = 4'd2,
		READ_SYS   = 4'd3,
		READ_DATA  = 4'd4,
		WRITE      = 4'd5,
		WRITE_HIT  = 4'd6,
		WRITE_MISS = 4'd7,
		WRITE_SYS  = 4'd8,
		WRITE_DATA = 4'd9
	} ctrl_state_e;

	// access direction, shared by the processor and system ports.
	typedef enum logic {
		RW_READ  = 1'b0,
		RW_WRITE = 1'b1
	} rw_e;

	// source of the word written into a cache line.
	typedef enum logic {
		CDATA_PRO = 1'b0,
		CDATA_SYS = 1'b1
	} cdata_sel_e;

	// source of the word returned to the processor.
	typedef enum logic {
		PDATA_CAC = 1'b0,
		PDATA_SYS = 1'b1
	} pdata_sel_e;

endpackage

// ==== mem_pkg.sv ====
package mem_pkg;

	// processor and system bus widths.
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// direct-mapped geometry with one word per line.
	// the index is the low address bits and the tag is the rest.
	localparam int INDEX_W = 4;
	localparam int TAG_W   = ADDR_W - INDEX_W;
	localparam int LINES   = 1 << INDEX_W;

	// system memory has no acknowledge, so every access is timed.
	// the counter is loaded with WAIT_STATES and runs down to zero.
	localparam int WAIT_STATES = 2;
	localparam int WSC_W       = 2;

endpackage
